/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_output_queues
RTL_TOP   ?= output_queues
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/axis_pkg.sv */
`include "oq_consts.svh"

package axis_pkg;

   // One data beat as stored in a queue
   typedef struct packed {
      logic [`OQ_DATA_WIDTH-1:0]   tdata;
      logic [`OQ_DATA_WIDTH/8-1:0] tstrb;
      logic                        tlast;
   } axis_beat_t;

   typedef logic [`OQ_USER_WIDTH-1:0] axis_user_t;

   // Everything a master port drives
   typedef struct packed {
      axis_beat_t beat;
      axis_user_t tuser;  // Constant across a packet
      logic       tvalid;
   } axis_out_t;

endpackage

/* logic/oq_admit.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_admit (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  axis_pkg::axis_beat_t s_beat,
   input  axis_pkg::axis_user_t s_user,
   input  logic                 s_valid,
   output logic                 s_ready,
   input  oq_pkg::queue_mask_t  data_full,
   input  oq_pkg::queue_mask_t  meta_full,
   output oq_pkg::queue_mask_t  wr_mask,
   output logic                 wr_first
);

   import oq_pkg::*;

   admit_state_t state;
   admit_state_t state_next;
   queue_mask_t  dst_mask;   // Decoded from the current tuser
   queue_mask_t  cur_mask;   // Held for the whole packet
   queue_mask_t  blocked;
   logic [7:0]   dst;
   logic         first_word;
   logic         xfer;

   assign dst = s_user[`OQ_DST_POS +: 8];

   // Even bits map one to one, any odd bit selects the last queue
   always_comb begin
      dst_mask = '0;
      for (int k = 0; k < `OQ_NUM_QUEUES - 1; k++) begin
         dst_mask[k] = dst[2*k];
      end
      dst_mask[`OQ_NUM_QUEUES-1] = dst[1] | dst[3] | dst[5] | dst[7];
   end

   // A selected queue without room for a max-size packet
   assign blocked = dst_mask & (data_full | meta_full);

   assign s_ready = (state == ADMIT_WRITE) || (state == ADMIT_DROP);
   assign xfer    = s_valid && s_ready;

   always_comb begin
      state_next = state;
      case (state)
         ADMIT_IDLE: begin
            if (s_valid) begin
               state_next = (blocked == '0) ? ADMIT_WRITE : ADMIT_DROP;
            end
         end
         ADMIT_WRITE, ADMIT_DROP: begin
            if (xfer && s_beat.tlast) begin
               state_next = ADMIT_IDLE;
            end
         end
         default: state_next = ADMIT_IDLE;
      endcase
   end

   // Queue writes only on accepted beats of an admitted packet
   always_comb begin
      wr_mask  = '0;
      wr_first = 1'b0;
      if (state == ADMIT_WRITE && s_valid) begin
         wr_mask  = cur_mask;
         wr_first = first_word;  // Also pushes tuser
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state      <= ADMIT_IDLE;
         cur_mask   <= '0;
         first_word <= 1'b0;
      end else begin
         state <= state_next;
         if (state == ADMIT_IDLE && s_valid) begin
            cur_mask   <= dst_mask;
            first_word <= 1'b1;
         end else if (xfer) begin
            first_word <= 1'b0;
         end
      end
   end

endmodule

/* logic/oq_consts.svh */
`ifndef OQ_CONSTS_SVH
`define OQ_CONSTS_SVH

// Stream widths
`define OQ_DATA_WIDTH       64
`define OQ_USER_WIDTH       128

`define OQ_NUM_QUEUES       5

// Buffer sizing in bytes
`define OQ_BUFFER_BYTES     4096
`define OQ_MAX_PKT_BYTES    1600

`define OQ_DATA_DEPTH_BITS  9   // 512 beats of 8 bytes
// Room left for one max-size packet, counted in beats
`define OQ_DATA_THRESH      ((`OQ_BUFFER_BYTES - `OQ_MAX_PKT_BYTES) / (`OQ_DATA_WIDTH / 8))

`define OQ_META_DEPTH_BITS  3   // 8 tuser entries

// Low bit of the destination byte in tuser
`define OQ_DST_POS          24

`endif

/* logic/oq_fifo.sv */
`timescale 1ns/1ps

module oq_fifo #(
   parameter int WIDTH       = 8,
   parameter int DEPTH_BITS  = 4,
   parameter int PROG_THRESH = 8
) (
   input  logic             axi_aclk,
   input  logic             axi_resetn,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full,
   output logic             prog_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   // Flag levels sized to the occupancy counter
   localparam logic [DEPTH_BITS:0] FULL_LEVEL = (DEPTH_BITS + 1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] NF_LEVEL   = (DEPTH_BITS + 1)'(DEPTH - 1);
   localparam logic [DEPTH_BITS:0] PF_LEVEL   = (DEPTH_BITS + 1)'(PROG_THRESH);

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;   // One extra bit so a full FIFO is distinct
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign full  = (count == FULL_LEVEL);
   assign do_wr = wr_en && !full;   // Overflow writes are lost
   assign do_rd = rd_en && !empty;

   // Head entry falls through to the output
   assign dout        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= NF_LEVEL);
   assign prog_full   = (count >= PF_LEVEL);

   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

endmodule

/* logic/oq_pkg.sv */
`include "oq_consts.svh"

package oq_pkg;

   // One bit per output queue, bit k is queue k
   typedef logic [`OQ_NUM_QUEUES-1:0] queue_mask_t;

   // Packet admission
   typedef enum logic [1:0] {
      ADMIT_IDLE  = 2'd0,  // Waiting for a first beat
      ADMIT_WRITE = 2'd1,  // Copying the packet into the selected queues
      ADMIT_DROP  = 2'd2   // Swallowing the packet
   } admit_state_t;

endpackage

/* logic/oq_port.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_port (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  logic                 wr_en,
   input  logic                 wr_first,
   input  axis_pkg::axis_beat_t beat,
   input  axis_pkg::axis_user_t user,
   output logic                 data_full,
   output logic                 meta_full,
   output axis_pkg::axis_out_t  m_out,
   input  logic                 m_ready
);

   import axis_pkg::*;

   axis_beat_t head_beat;
   axis_user_t head_user;
   logic       data_empty;
   logic       tvalid;
   logic       pop;
   logic       meta_pop;
   logic       meta_push;

   assign meta_push = wr_en && wr_first;   // One tuser entry per packet

   // Beats of stored packets
   oq_fifo #(
      .WIDTH       ($bits(axis_beat_t)),
      .DEPTH_BITS  (`OQ_DATA_DEPTH_BITS),
      .PROG_THRESH (`OQ_DATA_THRESH)
   ) data_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (wr_en),
      .din         (beat),
      .rd_en       (pop),
      .dout        (head_beat),
      .empty       (data_empty),
      .nearly_full (),
      .prog_full   (data_full)
   );

   // tuser of each stored packet, in packet order
   oq_fifo #(
      .WIDTH       ($bits(axis_user_t)),
      .DEPTH_BITS  (`OQ_META_DEPTH_BITS),
      .PROG_THRESH (1 << `OQ_META_DEPTH_BITS)
   ) meta_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (meta_push),
      .din         (user),
      .rd_en       (meta_pop),
      .dout        (head_user),
      .empty       (),
      .nearly_full (meta_full),
      .prog_full   ()
   );

   assign tvalid   = !data_empty;
   assign pop      = tvalid && m_ready;
   // Entry stays at the head until the packet has left
   assign meta_pop = pop && head_beat.tlast;

   assign m_out.beat   = head_beat;
   assign m_out.tuser  = head_user;
   assign m_out.tvalid = tvalid;

endmodule

/* logic/output_queues.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module output_queues (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  axis_pkg::axis_beat_t s_beat,
   input  axis_pkg::axis_user_t s_user,
   input  logic                 s_valid,
   output logic                 s_ready,
   output axis_pkg::axis_out_t  m_out [`OQ_NUM_QUEUES],
   input  oq_pkg::queue_mask_t  m_ready
);

   import oq_pkg::*;

   queue_mask_t wr_mask;
   queue_mask_t data_full;
   queue_mask_t meta_full;
   logic        wr_first;

   oq_admit admit (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .s_beat     (s_beat),
      .s_user     (s_user),
      .s_valid    (s_valid),
      .s_ready    (s_ready),
      .data_full  (data_full),
      .meta_full  (meta_full),
      .wr_mask    (wr_mask),
      .wr_first   (wr_first)
   );

   // Every queue sees the same beat, its mask bit decides the write
   for (genvar i = 0; i < `OQ_NUM_QUEUES; i++) begin : g_queue
      oq_port port (
         .axi_aclk   (axi_aclk),
         .axi_resetn (axi_resetn),
         .wr_en      (wr_mask[i]),
         .wr_first   (wr_first),
         .beat       (s_beat),
         .user       (s_user),
         .data_full  (data_full[i]),
         .meta_full  (meta_full[i]),
         .m_out      (m_out[i]),
         .m_ready    (m_ready[i])
      );
   end

endmodule

/* test/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int HALF_PERIOD = 5,
   parameter int RESET_CYCLES = 16
) (
   output logic axi_aclk,
   output logic axi_resetn
);

   initial begin
      axi_aclk = 1'b0;
      forever #(HALF_PERIOD) axi_aclk = ~axi_aclk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      axi_resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_resetn = 1'b1;
   end

endmodule

/* test/tb_output_queues.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module tb_output_queues;

   import axis_pkg::*;
   import oq_pkg::*;

   localparam int NQ         = `OQ_NUM_QUEUES;
   localparam int META_LIMIT = (1 << `OQ_META_DEPTH_BITS) - 1;
   localparam int TIMEOUT    = 5000;

   logic        axi_aclk;
   logic        axi_resetn;
   axis_beat_t  s_beat;
   axis_user_t  s_user;
   logic        s_valid;
   logic        s_ready;
   axis_out_t   m_out [NQ];
   queue_mask_t m_ready;
   queue_mask_t ready_hold;
   logic        stall_mode;
   logic        started;        // Set by the first s_valid

   // Reference model state per queue
   axis_beat_t exp_beat [NQ][$];
   axis_user_t exp_user [NQ][$];
   int         data_cnt [NQ];
   int         meta_cnt [NQ];
   int         pkt_out  [NQ];   // Packets seen leaving the DUT
   int         errors;
   int         checks;

   tb_clkgen clkgen (.axi_aclk(axi_aclk), .axi_resetn(axi_resetn));

   output_queues UUT (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .s_beat     (s_beat),
      .s_user     (s_user),
      .s_valid    (s_valid),
      .s_ready    (s_ready),
      .m_out      (m_out),
      .m_ready    (m_ready)
   );

   // Even bit 2k picks queue k and any odd bit the last queue
   function automatic queue_mask_t dst_to_mask(input logic [7:0] dst);
      queue_mask_t m;
      m = '0;
      for (int i = 0; i < 8; i++) begin
         if (dst[i]) begin
            if (i % 2 == 0) m[i/2] = 1'b1;
            else m[NQ-1] = 1'b1;
         end
      end
      return m;
   endfunction

   task automatic end_run();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   task automatic abort_run(input string what);
      errors++;
      $display("Timeout at %0t: %s", $time, what);
      end_run();
   endtask

   always @(negedge axi_aclk) begin
      m_ready <= stall_mode ? queue_mask_t'($urandom) : ready_hold;
   end

   // Compares every output transfer with the model
   always @(posedge axi_aclk) begin
      if (!started && axi_resetn) begin
         checks++;
         assert (!s_ready) else begin
            errors++;
            $display("Fail t=%0t s_ready got %b exp 0", $time, s_ready);
         end
      end
      for (int q = 0; q < NQ; q++) begin
         if (!started && axi_resetn) begin
            assert (!m_out[q].tvalid) else begin
               errors++;
               $display("Fail t=%0t m_out[%0d].tvalid got 1 exp 0", $time, q);
            end
         end
         if (m_out[q].tvalid && m_ready[q]) begin
            checks++;
            if (m_out[q].beat.tlast) begin
               pkt_out[q]++;
            end
            assert (exp_beat[q].size() != 0) else begin
               errors++;
               $display("Unexpected beat on queue %0d at %0t", q, $time);
            end
            if (exp_beat[q].size() != 0) begin
               assert (m_out[q].beat == exp_beat[q][0]) else begin
                  errors++;
                  $display("Fail t=%0t m_out[%0d].beat got %h exp %h",
                           $time, q, m_out[q].beat, exp_beat[q][0]);
               end
               assert (m_out[q].tuser == exp_user[q][0]) else begin
                  errors++;
                  $display("Fail t=%0t m_out[%0d].tuser got %h exp %h",
                           $time, q, m_out[q].tuser, exp_user[q][0]);
               end
               data_cnt[q]--;
               if (exp_beat[q][0].tlast) begin
                  meta_cnt[q]--;
               end
               void'(exp_beat[q].pop_front());
               void'(exp_user[q].pop_front());
            end
         end
      end
   end

   // Drives one packet and records what the queues should emit
   task automatic send_packet(input logic [7:0] dst, input int len);
      axis_user_t  user;
      axis_beat_t  b;
      queue_mask_t mask;
      logic        admitted;
      int          wait_cnt;
      user = {$urandom, $urandom, $urandom, $urandom};
      user[`OQ_DST_POS +: 8] = dst;
      mask = dst_to_mask(dst);
      admitted = 1'b1;
      for (int q = 0; q < NQ; q++) begin
         if (mask[q] && (data_cnt[q] >= `OQ_DATA_THRESH || meta_cnt[q] >= META_LIMIT))
            admitted = 1'b0;
      end
      for (int q = 0; q < NQ; q++) begin
         if (admitted && mask[q]) meta_cnt[q]++;
      end
      for (int i = 0; i < len; i++) begin
         b.tdata = {$urandom, $urandom};
         b.tstrb = $urandom;
         b.tlast = (i == len - 1);
         s_beat  = b;
         s_user  = user;
         s_valid = 1'b1;
         started = 1'b1;
         for (int q = 0; q < NQ; q++) begin
            if (admitted && mask[q]) begin
               exp_beat[q].push_back(b);
               exp_user[q].push_back(user);
               data_cnt[q]++;
            end
         end
         wait_cnt = 0;
         do begin
            @(posedge axi_aclk);
            wait_cnt++;
         end while (!s_ready && wait_cnt < TIMEOUT);
         if (!s_ready) abort_run("input beat was never accepted");
         @(negedge axi_aclk);
      end
      s_valid = 1'b0;
   endtask

   // Waits until the model is empty and no queue still offers a beat
   task automatic wait_drain();
      int   wait_cnt;
      logic busy;
      wait_cnt = 0;
      do begin
         @(negedge axi_aclk);
         wait_cnt++;
         busy = 1'b0;
         for (int q = 0; q < NQ; q++) begin
            if (exp_beat[q].size() != 0 || m_out[q].tvalid) begin
               busy = 1'b1;
            end
         end
      end while (busy && wait_cnt < TIMEOUT);
      if (busy) abort_run("queues did not drain");
   endtask

   initial begin
      int wait_cnt;
      int base;
      void'($urandom(32'h7669_6ad8));
      s_beat = '0;
      s_user = '0;
      s_valid = 1'b0;
      m_ready = '0;
      ready_hold = '1;
      stall_mode = 1'b0;
      started = 1'b0;
      errors = 0;
      checks = 0;
      for (int q = 0; q < NQ; q++) begin
         data_cnt[q] = 0;
         meta_cnt[q] = 0;
         pkt_out[q] = 0;
      end
      wait_cnt = 0;
      while (!axi_resetn && wait_cnt < TIMEOUT) begin
         @(negedge axi_aclk);
         wait_cnt++;
      end
      if (!axi_resetn) abort_run("reset was never released");
      repeat (10) @(negedge axi_aclk);  // Idle outputs are checked here

      for (int k = 0; k < 4; k++) begin
         send_packet(8'(1 << (2 * k)), 1 + ($urandom % 12));
      end
      send_packet(8'h06, 5);   // Copies on queues 1 and 4
      send_packet(8'h00, 3);   // Goes nowhere
      wait_drain();

      ready_hold = 5'b11110;        // Queue 0 stalled
      base = pkt_out[0];
      for (int p = 0; p < 5; p++) begin
         send_packet(8'h01, 100);   // Only four fit below the threshold
      end
      send_packet(8'h04, 6);
      ready_hold = '1;
      wait_drain();
      checks++;
      assert (pkt_out[0] - base == 4) else begin
         errors++;
         $display("Fail t=%0t queue0 drained packets got %0d exp 4",
                  $time, pkt_out[0] - base);
      end

      ready_hold = 5'b10111;        // Queue 3 stalled
      base = pkt_out[3];
      for (int p = 0; p < 8; p++) send_packet(8'h40, 1);
      ready_hold = '1;
      wait_drain();
      checks++;
      assert (pkt_out[3] - base == 7) else begin
         errors++;
         $display("Fail t=%0t queue3 drained packets got %0d exp 7",
                  $time, pkt_out[3] - base);
      end

      stall_mode = 1'b1;
      for (int p = 0; p < 40; p++) send_packet(8'($urandom), 1 + ($urandom % 20));
      wait_drain();
      stall_mode = 1'b0;
      end_run();
   end

endmodule

/* vlog.f */
+incdir+logic
logic/axis_pkg.sv
logic/oq_pkg.sv
logic/oq_fifo.sv
logic/oq_admit.sv
logic/oq_port.sv
logic/output_queues.sv
test/tb_clkgen.sv
test/tb_output_queues.sv
